// File: afu_rdwr.f
+incdir+hw
hw/host_mem_pkg.sv
hw/afu_csr_pkg.sv
hw/csr_mgr.sv
hw/host_mem_rdwr_engine.sv
hw/afu.sv
test/host_mem_model.sv
test/afu_tb.sv

// File: hw/afu.sv
// Exerciser accelerator top
// CSR manager plus one host memory read/write engine
`timescale 1ns/1ps
`default_nettype none

module afu
    import afu_csr_pkg::*;
    import host_mem_pkg::*;
#(
    parameter int AFU_INSTANCE_ID = 0
)
(
    input  wire              clk,
    input  wire              rst_n,

    // MMIO slave
    input  wire              wr_valid,
    output logic             wr_ready,
    input  wire mmio_wr_t    wr,
    output logic             b_valid,
    input  wire              b_ready,
    input  wire              ar_valid,
    output logic             ar_ready,
    input  wire mmio_rd_t    ar,
    output logic             r_valid,
    input  wire              r_ready,
    output mmio_data_t       r_data,

    // Host memory
    output logic             req_valid,
    input  wire              req_ready,
    output mem_req_t         req,
    input  wire              rsp_valid,
    input  wire mem_rsp_t    rsp
);

    eng_cfg_t    cfg;
    eng_status_t status;
    logic        start;
    logic        clear;

    // ==================================================================
    // Control via CSRs
    // ==================================================================

    csr_mgr #(
        .AFU_INSTANCE_ID (AFU_INSTANCE_ID)
    ) csr_mgr_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr       (wr),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_data   (r_data),
        .cfg      (cfg),
        .start    (start),
        .clear    (clear),
        .status   (status)
    );

    // ==================================================================
    // Single engine on the host memory port
    // ==================================================================

    host_mem_rdwr_engine eng_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .start     (start),
        .clear     (clear),
        .status    (status),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

`default_nettype wire

// File: hw/afu_csr_pkg.sv
// CSR side types for the exerciser
// MMIO channel payloads and engine configuration and status records
`default_nettype none

`include "afu_defines.svh"

package afu_csr_pkg;

    // Engine state enum lives with the host memory types
    import host_mem_pkg::*;

    typedef logic [`AFU_DATA_W-1:0] mmio_data_t;

    // Write channel payload, index and data travel together
    typedef struct packed {
        logic [`AFU_MMIO_IDX_W-1:0] idx;
        mmio_data_t                 data;
    } mmio_wr_t;

    // Read address channel payload
    typedef struct packed {
        logic [`AFU_MMIO_IDX_W-1:0] idx;
    } mmio_rd_t;

    // Engine CSR offsets from the engine base
    typedef enum logic [3:0] {
        CSR_CTRL      = 4'd0,   // bit 0 start, bit 1 clear
        CSR_RD_BASE   = 4'd1,
        CSR_WR_BASE   = 4'd2,
        CSR_NUM_LINES = 4'd3,
        CSR_WR_SEED   = 4'd4,
        CSR_STATUS    = 4'd5,   // bit 0 active, bit 1 done, bits 6:4 state
        CSR_LINES     = 4'd6,   // lines read low, lines written high
        CSR_CHECKSUM  = 4'd7,
        CSR_CYCLES    = 4'd8
    } eng_csr_idx_e;

    // Software controlled run parameters
    typedef struct packed {
        logic [`AFU_ADDR_W-1:0] rd_base;
        logic [`AFU_ADDR_W-1:0] wr_base;
        logic [31:0]            num_lines;
        logic [`AFU_DATA_W-1:0] seed;
    } eng_cfg_t;

    // Engine results seen by software
    typedef struct packed {
        eng_state_e             state;
        logic                   done;
        logic [31:0]            lines_rd;
        logic [31:0]            lines_wr;
        logic [`AFU_DATA_W-1:0] checksum;
        logic [63:0]            cycles;
    } eng_status_t;

endpackage

`default_nettype wire

// File: hw/afu_defines.svh
// Shared widths, limits and CSR constants for the host memory exerciser
// Test identifier halves are reported through the global CSRs
`ifndef AFU_DEFINES_SVH
`define AFU_DEFINES_SVH

// Data path and host address widths
`define AFU_DATA_W          64
`define AFU_ADDR_W          32

// MMIO word index width, 32 CSR words
`define AFU_MMIO_IDX_W      5

// Request tracking
`define AFU_MAX_OUTSTANDING 4
`define AFU_TAG_W           2

// Address step per 64-bit line
`define AFU_LINE_BYTES      8

// 128-bit test identifier, low and high words
`define AFU_TEST_ID_LO      64'h6c3e_21d4_a9b0_57f1
`define AFU_TEST_ID_HI      64'h0d7a_4e92_b815_c3a6

// First engine CSR word
`define AFU_ENG_CSR_BASE    16

`endif

// File: hw/csr_mgr.sv
// CSR manager for the exerciser
// AXI-lite style MMIO slave with global and engine CSR words
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module csr_mgr
    import afu_csr_pkg::*;
    import host_mem_pkg::*;
#(
    parameter int AFU_INSTANCE_ID = 0
)
(
    input  wire              clk,
    input  wire              rst_n,

    // MMIO write and write response
    input  wire              wr_valid,
    output logic             wr_ready,
    input  wire mmio_wr_t    wr,
    output logic             b_valid,
    input  wire              b_ready,

    // MMIO read address and read data
    input  wire              ar_valid,
    output logic             ar_ready,
    input  wire mmio_rd_t    ar,
    output logic             r_valid,
    input  wire              r_ready,
    output mmio_data_t       r_data,

    // Engine control
    output eng_cfg_t         cfg,
    output logic             start,
    output logic             clear,
    input  wire eng_status_t status
);

    localparam int OFF_W = $bits(eng_csr_idx_e);
    localparam logic [`AFU_MMIO_IDX_W-1:0] ENG_BASE = `AFU_ENG_CSR_BASE;

    logic         wr_fire;
    logic         ar_fire;
    logic         wr_eng;
    logic         ar_eng;
    logic         eng_active;
    eng_csr_idx_e wr_off;
    eng_csr_idx_e ar_off;
    mmio_data_t   rd_word;

    // ==================================================================
    // Write path
    // ==================================================================

    // One write in flight, blocked until the response drains
    assign wr_ready = !b_valid;
    assign wr_fire  = wr_valid && wr_ready;
    assign wr_eng   = (wr.idx >= ENG_BASE);
    assign wr_off   = eng_csr_idx_e'(OFF_W'(wr.idx - ENG_BASE));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            b_valid <= 1'b0;
        else if (wr_fire)
            b_valid <= 1'b1;
        else if (b_ready)
            b_valid <= 1'b0;
    end

    // Config registers and CTRL pulses
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cfg   <= '0;
            start <= 1'b0;
            clear <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            clear <= 1'b0;
            if (wr_fire && wr_eng)
            begin
                case (wr_off)
                    CSR_CTRL:
                    begin
                        // Clear wins over start
                        clear <= wr.data[1];
                        start <= wr.data[0] && !wr.data[1];
                    end
                    CSR_RD_BASE:   cfg.rd_base   <= wr.data[`AFU_ADDR_W-1:0];
                    CSR_WR_BASE:   cfg.wr_base   <= wr.data[`AFU_ADDR_W-1:0];
                    CSR_NUM_LINES: cfg.num_lines <= wr.data[31:0];
                    CSR_WR_SEED:   cfg.seed      <= wr.data;
                    // Status words are read only
                    default: ;
                endcase
            end
        end
    end

    // ==================================================================
    // Read path
    // ==================================================================

    assign ar_ready   = !r_valid;
    assign ar_fire    = ar_valid && ar_ready;
    assign ar_eng     = (ar.idx >= ENG_BASE);
    assign ar_off     = eng_csr_idx_e'(OFF_W'(ar.idx - ENG_BASE));
    assign eng_active = (status.state inside {ENG_READ, ENG_WRITE, ENG_DRAIN});

    // Read mux, unmapped words return zero
    always_comb
    begin
        rd_word = '0;
        if (ar_eng)
        begin
            case (ar_off)
                CSR_RD_BASE:   rd_word = mmio_data_t'(cfg.rd_base);
                CSR_WR_BASE:   rd_word = mmio_data_t'(cfg.wr_base);
                CSR_NUM_LINES: rd_word = mmio_data_t'(cfg.num_lines);
                CSR_WR_SEED:   rd_word = cfg.seed;
                CSR_STATUS:
                    rd_word = {57'd0, status.state, 2'b00, status.done, eng_active};
                CSR_LINES:     rd_word = {status.lines_wr, status.lines_rd};
                CSR_CHECKSUM:  rd_word = status.checksum;
                CSR_CYCLES:    rd_word = status.cycles;
                default: ;
            endcase
        end
        else
        begin
            case (ar.idx)
                5'd0: rd_word = `AFU_TEST_ID_LO;
                5'd1: rd_word = `AFU_TEST_ID_HI;
                // Instance number and a single engine
                5'd2: rd_word = {32'd0, 8'(AFU_INSTANCE_ID), 16'd0, 8'd1};
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            r_valid <= 1'b0;
        else if (ar_fire)
            r_valid <= 1'b1;
        else if (r_ready)
            r_valid <= 1'b0;
    end

    // Response data captured at acceptance
    always_ff @(posedge clk)
    begin
        if (ar_fire)
            r_data <= rd_word;
    end

    // ==================================================================
    // Checks
    // ==================================================================

    a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> $stable(r_data));

    a_ctrl_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(start && clear));

endmodule

`default_nettype wire

// File: hw/host_mem_pkg.sv
// Host memory side types
// Request and response payloads plus the engine state encoding
`default_nettype none

`include "afu_defines.svh"

package host_mem_pkg;

    typedef enum logic {
        MEM_RD = 1'b0,
        MEM_WR = 1'b1
    } mem_op_e;

    // Request payload, data only meaningful for writes
    typedef struct packed {
        mem_op_e                op;
        logic [`AFU_ADDR_W-1:0] addr;
        logic [`AFU_DATA_W-1:0] data;
        logic [`AFU_TAG_W-1:0]  tag;
    } mem_req_t;

    // In-order response, one per request
    typedef struct packed {
        mem_op_e                op;
        logic [`AFU_TAG_W-1:0]  tag;
        logic [`AFU_DATA_W-1:0] data;
    } mem_rsp_t;

    // Engine run phases
    typedef enum logic [2:0] {
        ENG_IDLE  = 3'd0,
        ENG_READ  = 3'd1,
        ENG_WRITE = 3'd2,
        ENG_DRAIN = 3'd3,
        ENG_DONE  = 3'd4
    } eng_state_e;

endpackage

`default_nettype wire

// File: hw/host_mem_rdwr_engine.sv
// Host memory read/write engine
// Reads lines into an XOR checksum, then writes seed plus index per line
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module host_mem_rdwr_engine
    import afu_csr_pkg::*;
    import host_mem_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    // Control from the CSR manager
    input  wire eng_cfg_t    cfg,
    input  wire              start,
    input  wire              clear,
    output eng_status_t      status,

    // Host memory request and response
    output logic             req_valid,
    input  wire              req_ready,
    output mem_req_t         req,
    input  wire              rsp_valid,
    input  wire mem_rsp_t    rsp
);

    localparam int ADDR_W = `AFU_ADDR_W;
    localparam int DATA_W = `AFU_DATA_W;
    localparam int OUT_W  = $clog2(`AFU_MAX_OUTSTANDING + 1);

    eng_state_e             state;
    eng_cfg_t               cfg_q;
    logic                   active;
    logic                   launch;
    logic                   issue_rd;
    logic                   req_fire;
    logic                   last_issue;
    logic [31:0]            rd_issued;
    logic [31:0]            wr_issued;
    logic [31:0]            line_idx;
    logic [ADDR_W-1:0]      line_off;
    logic [31:0]            lines_rd;
    logic [31:0]            lines_wr;
    logic [DATA_W-1:0]      checksum;
    logic [63:0]            cycles;
    logic [OUT_W-1:0]       outstanding;
    logic [OUT_W-1:0]       outstanding_nxt;
    logic [`AFU_TAG_W-1:0]  next_tag;
    logic [`AFU_TAG_W-1:0]  exp_tag;

    assign active = (state inside {ENG_READ, ENG_WRITE, ENG_DRAIN});
    // Start is ignored mid-run
    assign launch = start && !active && !clear;

    // ==================================================================
    // Request issue
    // ==================================================================

    assign issue_rd   = (state == ENG_READ);
    assign line_idx   = issue_rd ? rd_issued : wr_issued;
    assign line_off   = ADDR_W'(line_idx) * ADDR_W'(`AFU_LINE_BYTES);
    assign last_issue = (line_idx == cfg_q.num_lines - 32'd1);

    // Valid drops at the outstanding limit
    assign req_valid = (state == ENG_READ || state == ENG_WRITE) &&
                       (outstanding < OUT_W'(`AFU_MAX_OUTSTANDING));
    assign req_fire  = req_valid && req_ready;

    // Built from registers that move only on fire, so stable under stall
    always_comb
    begin
        req.op   = issue_rd ? MEM_RD : MEM_WR;
        req.addr = (issue_rd ? cfg_q.rd_base : cfg_q.wr_base) + line_off;
        req.data = issue_rd ? '0 : cfg_q.seed + DATA_W'(line_idx);
        req.tag  = next_tag;
    end

    assign outstanding_nxt = outstanding + OUT_W'(req_fire) - OUT_W'(rsp_valid);

    // ==================================================================
    // Run FSM
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n || clear)
            state <= ENG_IDLE;
        else
        begin
            case (state)
                ENG_IDLE, ENG_DONE:
                    if (launch)
                        state <= (cfg.num_lines == 32'd0) ? ENG_DRAIN : ENG_READ;
                ENG_READ:
                    if (req_fire && last_issue)
                        state <= ENG_WRITE;
                ENG_WRITE:
                    if (req_fire && last_issue)
                        state <= ENG_DRAIN;
                // Done the cycle after the last response
                ENG_DRAIN:
                    if (outstanding_nxt == '0)
                        state <= ENG_DONE;
                default:
                    state <= ENG_IDLE;
            endcase
        end
    end

    // Run parameters held for the whole run
    always_ff @(posedge clk)
    begin
        if (launch)
            cfg_q <= cfg;
    end

    // ==================================================================
    // Counters and checksum
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n || clear || launch)
        begin
            rd_issued <= '0;
            wr_issued <= '0;
            lines_rd  <= '0;
            lines_wr  <= '0;
            checksum  <= '0;
            cycles    <= '0;
        end
        else
        begin
            if (req_fire && issue_rd)
                rd_issued <= rd_issued + 32'd1;
            if (req_fire && !issue_rd)
                wr_issued <= wr_issued + 32'd1;
            // Response opcode picks the counter
            if (rsp_valid && rsp.op == MEM_RD)
            begin
                lines_rd <= lines_rd + 32'd1;
                checksum <= checksum ^ rsp.data;
            end
            if (rsp_valid && rsp.op == MEM_WR)
                lines_wr <= lines_wr + 32'd1;
            if (active)
                cycles <= cycles + 64'd1;
        end
    end

    // Tracking survives clear, late responses still drain
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            outstanding <= '0;
            next_tag    <= '0;
            exp_tag     <= '0;
        end
        else
        begin
            outstanding <= outstanding_nxt;
            if (req_fire)
                next_tag <= next_tag + 1'b1;
            if (rsp_valid)
                exp_tag <= exp_tag + 1'b1;
        end
    end

    always_comb
    begin
        status.state    = state;
        status.done     = (state == ENG_DONE);
        status.lines_rd = lines_rd;
        status.lines_wr = lines_wr;
        status.checksum = checksum;
        status.cycles   = cycles;
    end

    // ==================================================================
    // Checks
    // ==================================================================

    a_out_limit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= OUT_W'(`AFU_MAX_OUTSTANDING));

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req));

    a_rsp_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> outstanding != '0);

    a_rsp_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> rsp.tag == exp_tag);

endmodule

`default_nettype wire

// File: test/afu_tb.sv
// Testbench for the host memory exerciser
// MMIO driven runs checked against a behavioral host memory
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module afu_tb
    import afu_csr_pkg::*;
    import host_mem_pkg::*;
();

    localparam int          CLK_HALF  = 2;
    localparam int          INSTANCE  = 3;
    localparam int          LOG_LINES = 64;
    localparam int          MAX_LAT   = 4;
    localparam logic [63:0] RD_XOR    = 64'h5a5a_0f0f_c3c3_9696;
    localparam logic [31:0] SEED      = 32'h3a0681ef;
    // Two requests per line at full latency plus MMIO traffic, then doubled
    localparam int RUN_LINES     = 16 + 40 + 24;
    localparam int MMIO_OPS      = 80;
    localparam int BUDGET_CYCLES = 2 * (2 * RUN_LINES * (MAX_LAT + 1) + MMIO_OPS * 10);

    logic                   clk;
    logic                   rst_n;
    logic                   wr_valid;
    logic                   wr_ready;
    mmio_wr_t               wr;
    logic                   b_valid;
    logic                   b_ready;
    logic                   ar_valid;
    logic                   ar_ready;
    mmio_rd_t               ar;
    logic                   r_valid;
    logic                   r_ready;
    mmio_data_t             r_data;
    logic                   req_valid;
    logic                   req_ready;
    mem_req_t               req;
    logic                   rsp_valid;
    mem_rsp_t               rsp;
    logic                   rand_ready;
    logic [3:0]             lat_min;
    logic [3:0]             lat_max;
    logic [`AFU_ADDR_W-1:0] log_base;
    logic                   log_clear;
    int                     errors;
    int                     err_mark;
    int                     tests_run;
    int                     tests_failed;
    int                     in_flight;
    logic [`AFU_TAG_W-1:0]  exp_req_tag;

    afu #(.AFU_INSTANCE_ID(INSTANCE)) dut_i (.*);

    host_mem_model #(.LOG_LINES(LOG_LINES), .RD_XOR(RD_XOR)) mem_i (.*);

    always #CLK_HALF clk = ~clk;

    // ==================================================================
    // Port checks
    // ==================================================================

    // Requests accepted but not yet answered, and the tag due next
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            in_flight   <= 0;
            exp_req_tag <= '0;
        end
        else
        begin
            in_flight <= in_flight + ((req_valid && req_ready) ? 1 : 0) - (rsp_valid ? 1 : 0);
            if (req_valid && req_ready)
                exp_req_tag <= exp_req_tag + 1'b1;
        end
    end

    a_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        in_flight <= `AFU_MAX_OUTSTANDING)
        else report_failure("too many memory requests in flight");

    // Tags step by one per accepted request
    a_req_tag: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> req.tag == exp_req_tag)
        else report_failure("memory request tag out of sequence");

    a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else report_failure("memory request changed under stall");

    a_rdata_hold: assert property (@(posedge clk) disable iff (!rst_n)
        r_valid && !r_ready |=> $stable(r_data))
        else report_failure("MMIO read data changed under stall");

    // ==================================================================
    // Helpers
    // ==================================================================

    task automatic report_failure(input string what);
        $display("FAIL: %s", what);
        errors++;
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp)
        else
        begin
            $display("ERROR %s expected 0x%h actual 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1)
        else report_failure(what);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != err_mark)
            tests_failed++;
        $display("test %-22s %s", name, (errors != err_mark) ? "FAIL" : "ok");
        err_mark = errors;
    endtask

    function automatic logic [`AFU_MMIO_IDX_W-1:0] eng_idx(input eng_csr_idx_e off);
        return `AFU_MMIO_IDX_W'(`AFU_ENG_CSR_BASE + int'(off));
    endfunction

    task automatic csr_write(input logic [`AFU_MMIO_IDX_W-1:0] idx, input logic [63:0] data);
        @(negedge clk);
        wr_valid = 1'b1;
        wr.idx   = idx;
        wr.data  = data;
        while (!wr_ready)
            @(negedge clk);
        @(negedge clk);
        wr_valid = 1'b0;
        repeat ($urandom_range(0, 3))
            @(negedge clk);
        check_true(b_valid, "write response did not arrive");
        b_ready = 1'b1;
        @(negedge clk);
        b_ready = 1'b0;
    endtask

    task automatic csr_read(input logic [`AFU_MMIO_IDX_W-1:0] idx, output logic [63:0] data);
        @(negedge clk);
        ar_valid = 1'b1;
        ar.idx   = idx;
        while (!ar_ready)
            @(negedge clk);
        @(negedge clk);
        ar_valid = 1'b0;
        // Random stall exercises the held read data
        repeat ($urandom_range(0, 3))
            @(negedge clk);
        check_true(r_valid, "read response did not arrive");
        data    = r_data;
        r_ready = 1'b1;
        @(negedge clk);
        r_ready = 1'b0;
    endtask

    task automatic configure_run(input logic [31:0] rd_base, input logic [31:0] wr_base,
                                 input int n, input logic [63:0] seed);
        csr_write(eng_idx(CSR_RD_BASE), 64'(rd_base));
        csr_write(eng_idx(CSR_WR_BASE), 64'(wr_base));
        csr_write(eng_idx(CSR_NUM_LINES), 64'(n));
        csr_write(eng_idx(CSR_WR_SEED), seed);
        log_base  = wr_base;
        log_clear = 1'b1;
        @(negedge clk);
        log_clear = 1'b0;
    endtask

    task automatic wait_done();
        logic [63:0] st;
        do
            csr_read(eng_idx(CSR_STATUS), st);
        while (!st[1]);
    endtask

    // XOR of model data over the read addresses
    function automatic logic [63:0] expected_checksum(input logic [31:0] base, input int n);
        logic [63:0] sum;
        sum = '0;
        for (int i = 0; i < n; i++)
            sum ^= 64'(base + 32'(i * `AFU_LINE_BYTES)) ^ RD_XOR;
        return sum;
    endfunction

    task automatic check_results(input logic [31:0] rd_base, input int n);
        logic [63:0] rd;
        csr_read(eng_idx(CSR_CHECKSUM), rd);
        check_val("CHECKSUM", expected_checksum(rd_base, n), rd);
        csr_read(eng_idx(CSR_LINES), rd);
        check_val("LINES", {32'(n), 32'(n)}, rd);
        csr_read(eng_idx(CSR_STATUS), rd);
        check_val("STATUS", {57'd0, ENG_DONE, 4'b0010}, rd);
        // At most one request per active cycle
        csr_read(eng_idx(CSR_CYCLES), rd);
        check_true(rd >= 64'(2 * n), "cycle count shorter than the request count");
    endtask

    task automatic check_writes(input int n, input logic [63:0] seed);
        for (int i = 0; i < LOG_LINES; i++)
        begin
            check_val($sformatf("write count line %0d", i), (i < n) ? 1 : 0, mem_i.wr_hits[i]);
            if (i < n)
                check_val($sformatf("wr_val[%0d]", i), seed + 64'(i), mem_i.wr_val[i]);
        end
        check_val("stray writes", 0, mem_i.stray);
    endtask

    // ==================================================================
    // Test sequence
    // ==================================================================

    initial
    begin
        logic [63:0] rd;
        void'($urandom(SEED));
        clk        = 1'b0;
        rst_n      = 1'b0;
        wr_valid   = 1'b0;
        wr         = '0;
        b_ready    = 1'b0;
        ar_valid   = 1'b0;
        ar         = '0;
        r_ready    = 1'b0;
        rand_ready = 1'b0;
        lat_min    = 4'd1;
        lat_max    = 4'd2;
        log_base   = '0;
        log_clear  = 1'b0;
        errors     = 0;
        err_mark   = 0;
        tests_run  = 0;
        tests_failed = 0;
        repeat (3)
            @(negedge clk);
        rst_n = 1'b1;

        check_val("b_valid", 0, b_valid);
        check_val("r_valid", 0, r_valid);
        check_val("req_valid", 0, req_valid);
        csr_read(5'd0, rd);
        check_val("TEST_ID_LO", `AFU_TEST_ID_LO, rd);
        csr_read(5'd1, rd);
        check_val("TEST_ID_HI", `AFU_TEST_ID_HI, rd);
        // Instance in bits 31:24 and engine count in bits 7:0
        csr_read(5'd2, rd);
        check_val("CONFIG", (64'(INSTANCE) << 24) | 64'd1, rd);
        csr_read(5'd7, rd);
        check_val("unmapped global", 0, rd);
        csr_read(5'(`AFU_ENG_CSR_BASE + 12), rd);
        check_val("unmapped engine", 0, rd);
        end_test("reset and ids");

        configure_run(32'h0001_0000, 32'h0002_0000, 16, 64'h1234_5678_9abc_def0);
        csr_read(eng_idx(CSR_RD_BASE), rd);
        check_val("RD_BASE", 64'h0001_0000, rd);
        csr_read(eng_idx(CSR_WR_BASE), rd);
        check_val("WR_BASE", 64'h0002_0000, rd);
        csr_read(eng_idx(CSR_NUM_LINES), rd);
        check_val("NUM_LINES", 64'd16, rd);
        csr_read(eng_idx(CSR_WR_SEED), rd);
        check_val("WR_SEED", 64'h1234_5678_9abc_def0, rd);
        end_test("config readback");

        csr_write(eng_idx(CSR_CTRL), 64'h1);
        wait_done();
        check_results(32'h0001_0000, 16);
        end_test("run 16 lines");
        check_writes(16, 64'h1234_5678_9abc_def0);
        end_test("run 16 writes");

        // Random readiness at full latency keeps the limit busy
        rand_ready = 1'b1;
        lat_min    = 4'(MAX_LAT);
        lat_max    = 4'(MAX_LAT);
        configure_run(32'h0004_0100, 32'h0008_0000, 40, 64'hfedc_0000_0000_fff0);
        csr_write(eng_idx(CSR_CTRL), 64'h1);
        wait_done();
        check_results(32'h0004_0100, 40);
        check_writes(40, 64'hfedc_0000_0000_fff0);
        end_test("run 40 lines stalled");

        csr_write(eng_idx(CSR_CTRL), 64'h2);
        csr_read(eng_idx(CSR_STATUS), rd);
        check_val("STATUS", 0, rd);
        csr_read(eng_idx(CSR_LINES), rd);
        check_val("LINES", 0, rd);
        csr_read(eng_idx(CSR_CHECKSUM), rd);
        check_val("CHECKSUM", 0, rd);
        csr_read(eng_idx(CSR_CYCLES), rd);
        check_val("CYCLES", 0, rd);
        end_test("clear");

        lat_min = 4'd1;
        configure_run(32'h000c_0000, 32'h0010_0040, 24, 64'h0000_0001_0000_0000);
        csr_write(eng_idx(CSR_CTRL), 64'h1);
        // New line count and a second start land mid-run
        csr_write(eng_idx(CSR_NUM_LINES), 64'd5);
        csr_write(eng_idx(CSR_CTRL), 64'h1);
        csr_read(eng_idx(CSR_STATUS), rd);
        check_true(rd[0], "run ended before the second start");
        wait_done();
        check_results(32'h000c_0000, 24);
        check_writes(24, 64'h0000_0001_0000_0000);
        end_test("start while active");

        $display("%0d tests run, %0d failing, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial
    begin
        #(BUDGET_CYCLES * 2 * CLK_HALF);
        $display("watchdog expired after %0d cycles, run did not finish", BUDGET_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/host_mem_model.sv
// Behavioral host memory for the exerciser testbench
// In-order responses after a random latency, write log indexed by line
`timescale 1ns/1ps
`default_nettype none

`include "afu_defines.svh"

module host_mem_model
    import host_mem_pkg::*;
#(
    parameter int                     LOG_LINES = 64,
    parameter logic [`AFU_DATA_W-1:0] RD_XOR    = '0
)
(
    input  wire                   clk,
    input  wire                   rand_ready,
    input  wire [3:0]             lat_min,
    input  wire [3:0]             lat_max,
    input  wire [`AFU_ADDR_W-1:0] log_base,
    input  wire                   log_clear,
    input  wire                   req_valid,
    output logic                  req_ready,
    input  wire mem_req_t         req,
    output logic                  rsp_valid,
    output mem_rsp_t              rsp
);

    mem_req_t               pend_req[$];
    int unsigned            pend_due[$];
    int unsigned            cycle;
    int                     stray;
    int                     wr_hits[LOG_LINES];
    logic [`AFU_DATA_W-1:0] wr_val[LOG_LINES];

    // Writes land in the log by line offset from log_base
    task automatic log_write(input logic [`AFU_ADDR_W-1:0] addr,
                             input logic [`AFU_DATA_W-1:0] data);
        logic [`AFU_ADDR_W-1:0] off;
        off = addr - log_base;
        if (addr < log_base || off[2:0] != 3'd0 || (off >> 3) >= LOG_LINES)
            stray++;
        else
        begin
            wr_hits[off >> 3]++;
            wr_val[off >> 3] = data;
        end
    endtask

    initial
    begin
        req_ready = 1'b0;
        rsp_valid = 1'b0;
        rsp       = '0;
        cycle     = 0;
        stray     = 0;
        foreach (wr_hits[i])
            wr_hits[i] = 0;
    end

    always @(posedge clk)
    begin
        if (log_clear)
        begin
            stray = 0;
            foreach (wr_hits[i])
                wr_hits[i] = 0;
        end
    end

    // Outputs move on the falling edge, DUT samples them on the rising one
    always @(negedge clk)
    begin
        mem_req_t head;
        bit       ready_draw;
        cycle++;
        // Drawn every cycle so the random stream never depends on mode
        ready_draw = ($urandom_range(0, 3) != 0);
        rsp_valid  = 1'b0;
        rsp        = '0;
        if (pend_req.size() != 0 && pend_due[0] <= cycle)
        begin
            head = pend_req.pop_front();
            void'(pend_due.pop_front());
            rsp_valid = 1'b1;
            rsp.op    = head.op;
            rsp.tag   = head.tag;
            rsp.data  = (head.op == MEM_RD) ? (`AFU_DATA_W'(head.addr) ^ RD_XOR) : '0;
        end
        req_ready = rand_ready ? ready_draw : 1'b1;
        // Request fires on the next rising edge
        if (req_valid && req_ready)
        begin
            pend_req.push_back(req);
            pend_due.push_back(cycle + $urandom_range(lat_min, lat_max));
            if (req.op == MEM_WR)
                log_write(req.addr, req.data);
        end
    end

endmodule

`default_nettype wire
